// File: tests/fmau_mult_input.txt
# fmt (8 double, 4 single, 2 half, 1 bf16)  id_reg  srcv0  srcv1  pipe_down  warm_up
# last column is the expected 106-bit fraction product, 27 hex digits
# Double corners, zero fractions, all ones, one-sided
8 0 3FF0000000000000 4000000000000000 1 0 100000000000000000000000000
8 0 3FFFFFFFFFFFFFFF BFFFFFFFFFFFFFFF 1 0 3FFFFFFFFFFFFC0000000000001
8 0 7FEFFFFFFFFFFFFF 0010000000000000 1 0 1FFFFFFFFFFFFF0000000000000
# Double single-bit fractions
8 0 3FF8000000000000 3FF0000000000001 1 0 180000000000018000000000000
8 0 3FF0000000000001 3FF0000000000001 1 0 100000000000020000000000001
# Double mixed fractions
8 0 4015555555555555 C030000000000000 1 0 155555555555550000000000000
8 0 0005555555555555 000FFFFFFFFFFFFF 1 0 2AAAAAAAAAAAA8AAAAAAAAAAAAB
8 0 3FF0000000000123 3FF0000000000456 1 0 10000000000579000000004EDC2
8 0 3FFF000000000000 3FF0000000000FFF 1 0 1F000000001EFE1000000000000
# Double denormal operands
8 3 0008000000000000 8008000000000000 1 0 040000000000000000000000000
8 1 000FFFFFFFFFFFFF 3FF0000000000000 1 0 0FFFFFFFFFFFFF0000000000000
8 2 3FF0000000000000 0000000000000001 1 0 000000000000010000000000000
8 3 0000000000000000 8000000000000000 1 0 000000000000000000000000000
# Single precision
4 0 DEADBEEF3FC00000 123456783F800001 1 0 180000300000000000000000000
4 0 00000000007FFFFF FFFFFFFF7FFFFFFF 1 0 3FFFFF800000400000000000000
4 2 0000000000000000 00000000007FFFFF 1 0 0FFFFFE00000000000000000000
# Half precision
2 0 0000000000003BFF 0000000000003E00 1 0 2FFA00000000000000000000000
2 1 0000000000000200 0000000000000000 1 0 080000000000000000000000000
2 0 00000000000003FF 00000000000003FF 1 0 3FF001000000000000000000000
# Bfloat16
1 0 0000000000003FC0 0000000000003F81 1 0 183000000000000000000000000
1 0 000000000000007F 000000000000007F 1 0 3F8040000000000000000000000
1 3 0000000000000040 0000000000000040 1 0 040000000000000000000000000
# Warm-up loads without valid, then real traffic
8 0 3FF8000000000000 3FF0000000000001 0 1 180000000000018000000000000
4 0 00000000007FFFFF FFFFFFFF7FFFFFFF 0 1 3FFFFF800000400000000000000
8 0 3FF0000000000000 4000000000000000 1 0 100000000000000000000000000
8 0 3FFFFFFFFFFFFFFF BFFFFFFFFFFFFFFF 1 1 3FFFFFFFFFFFFC0000000000001
1 0 0000000000003FC0 0000000000003F81 0 1 183000000000000000000000000
2 0 0000000000003BFF 0000000000003E00 1 0 2FFA00000000000000000000000

// File: tb.f
common/fmau_pkg.sv
hdl/fmau_frac_unpack.sv
frac_mult/fmau_partial_mult.sv
frac_mult/fmau_frac_mult.sv
hdl/fmau_mult_top.sv
tests/tb_fmau_mult.sv

// File: Bender.yml
package:
  name: fmau_mult

dependencies: {}

sources:
  # Shared package first
  - files:
      - common/fmau_pkg.sv

  # Design
  - files:
      - hdl/fmau_frac_unpack.sv
      - frac_mult/fmau_partial_mult.sv
      - frac_mult/fmau_frac_mult.sv
      - hdl/fmau_mult_top.sv

  # Testbench
  - target: test
    files:
      - tests/tb_fmau_mult.sv

// File: tests/tb_fmau_mult.sv
module tb_fmau_mult;

  timeunit 1ns;
  timeprecision 1ps;

  // One line of the vector file
  typedef struct packed {
    fmau_pkg::fmau_ex1_req_t req;
    logic                    pipe_down;
    logic                    warm_up;
    fmau_pkg::fmau_prod_t    prod;
  } vec_t;

  logic                    fmau_ex2_data_clk;
  logic                    rst_n;
  fmau_pkg::fmau_ex1_req_t req;
  logic                    ctrl_dp_ex1_inst_pipe_down;
  logic                    ifu_vpu_warm_up;
  fmau_pkg::fmau_prod_t    ex2_mult_data;
  logic                    ex2_mult_vld;

  vec_t        vecs[$];
  vec_t        drv;
  vec_t        held;
  logic        held_ok;
  int unsigned cycle_count;
  int unsigned cycle_limit;

  fmau_mult_top #(
    .lo_split (fmau_pkg::lo_split)
  ) i_dut (
    .fmau_ex2_data_clk          (fmau_ex2_data_clk),
    .rst_n                      (rst_n),
    .req                        (req),
    .ctrl_dp_ex1_inst_pipe_down (ctrl_dp_ex1_inst_pipe_down),
    .ifu_vpu_warm_up            (ifu_vpu_warm_up),
    .ex2_mult_data              (ex2_mult_data),
    .ex2_mult_vld               (ex2_mult_vld)
  );

  initial
  begin
    fmau_ex2_data_clk = 1'b0;
    forever #5 fmau_ex2_data_clk = ~fmau_ex2_data_clk;
  end

  // ========================================
  // Failure handling and compare tasks
  // ========================================

  task automatic stop_on_failure();
    $display("Errors found");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_prod(input string name, input fmau_pkg::fmau_prod_t exp,
                            input fmau_pkg::fmau_prod_t act);
    if (act !== exp)
    begin
      $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_vld(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  // Narrow fractions sit shifted up by (double - narrow) bits in each operand
  function automatic fmau_pkg::fmau_prod_t low_zero_mask(input fmau_pkg::fmau_fmt_t fmt);
    int unsigned          offset;
    fmau_pkg::fmau_prod_t one_bit;
    offset = 0;
    one_bit = 1;
    if (fmt.single)
      offset = fmau_pkg::double_frac - fmau_pkg::single_frac;
    else if (fmt.f16)
      offset = fmau_pkg::double_frac - fmau_pkg::f16_frac;
    else if (fmt.bf16)
      offset = fmau_pkg::double_frac - fmau_pkg::bf16_frac;
    return (one_bit << (2 * offset)) - 1;
  endfunction

  // ========================================
  // Vector file
  // ========================================

  task automatic load_vectors();
    int                   fd;
    int                   code;
    string                line;
    logic [3:0]           f_fmt;
    logic [1:0]           f_id;
    logic [63:0]          f_src0;
    logic [63:0]          f_src1;
    logic                 f_pipe;
    logic                 f_warm;
    fmau_pkg::fmau_prod_t f_prod;
    vec_t                 v;
    fd = $fopen("tests/fmau_mult_input.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file tests/fmau_mult_input.txt");
      stop_on_failure();
    end
    while (!$feof(fd))
    begin
      line = "";
      code = $fgets(line, fd);
      // Skip comments and blank lines
      if (code == 0 || line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
        continue;
      code = $sscanf(line, "%h %h %h %h %h %h %h",
                     f_fmt, f_id, f_src0, f_src1, f_pipe, f_warm, f_prod);
      if (code != 7)
      begin
        $display("Malformed line in vector file: %s", line);
        stop_on_failure();
      end
      v.req.fmt = f_fmt;
      v.req.id_reg = f_id;
      v.req.srcv0 = f_src0;
      v.req.srcv1 = f_src1;
      v.pipe_down = f_pipe;
      v.warm_up = f_warm;
      v.prod = f_prod;
      vecs.push_back(v);
    end
    $fclose(fd);
  endtask

  // ========================================
  // One clock of stimulus and checking
  // ========================================

  task automatic run_cycle(input vec_t v);
    logic exp_vld;
    @(posedge fmau_ex2_data_clk);
    // This edge captured what was driven on the previous one
    if (drv.pipe_down || drv.warm_up)
    begin
      held = drv;
      held_ok = 1'b1;
    end
    exp_vld = drv.pipe_down;
    req <= v.req;
    ctrl_dp_ex1_inst_pipe_down <= v.pipe_down;
    ifu_vpu_warm_up <= v.warm_up;
    drv = v;
    @(negedge fmau_ex2_data_clk);
    check_vld("ex2_mult_vld", exp_vld, ex2_mult_vld);
    if (held_ok)
    begin
      check_prod("ex2_mult_data", held.prod, ex2_mult_data);
      if (!held.req.fmt.double)
        check_prod("ex2_mult_data low bits", '0,
                   ex2_mult_data & low_zero_mask(held.req.fmt));
    end
  endtask

  // Run length guard
  always @(posedge fmau_ex2_data_clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  initial
  begin
    vec_t        idle;
    int unsigned gap;
    void'($urandom(32'h2ddb));
    rst_n = 1'b0;
    req = '0;
    // Pipe-down high through reset, valid must still come out cleared
    ctrl_dp_ex1_inst_pipe_down = 1'b1;
    ifu_vpu_warm_up = 1'b0;
    drv = '0;
    held = '0;
    held_ok = 1'b0;
    cycle_count = 0;
    cycle_limit = 0;
    load_vectors();
    cycle_limit = vecs.size() * 4 + 20;

    @(posedge fmau_ex2_data_clk);
    @(negedge fmau_ex2_data_clk);
    check_vld("ex2_mult_vld", 1'b0, ex2_mult_vld);
    @(posedge fmau_ex2_data_clk);
    rst_n <= 1'b1;
    ctrl_dp_ex1_inst_pipe_down <= 1'b0;
    @(negedge fmau_ex2_data_clk);
    check_vld("ex2_mult_vld", 1'b0, ex2_mult_vld);

    // Idle after reset, valid must stay low
    idle = '0;
    repeat (3) run_cycle(idle);

    // Even entries run back to back into the next one
    foreach (vecs[i])
    begin
      run_cycle(vecs[i]);
      if (i % 2 == 1)
      begin
        gap = 1 + $urandom % 3;
        idle = vecs[i];
        idle.pipe_down = 1'b0;
        idle.warm_up = 1'b0;
        // Other operands on the inputs, the held product must not follow
        idle.req.srcv0 = ~vecs[i].req.srcv0;
        idle.req.srcv1 = ~vecs[i].req.srcv1;
        repeat (gap) run_cycle(idle);
      end
    end

    // Drain the last product and one hold cycle
    idle = drv;
    idle.pipe_down = 1'b0;
    idle.warm_up = 1'b0;
    repeat (2) run_cycle(idle);

    if (vecs.size() == 0)
    begin
      $display("The vector file held no vectors");
      stop_on_failure();
    end
    else
    begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: hdl/fmau_mult_top.sv
module fmau_mult_top #(
  parameter int unsigned lo_split = fmau_pkg::lo_split
) (
  input  logic                    fmau_ex2_data_clk,
  input  logic                    rst_n,
  input  fmau_pkg::fmau_ex1_req_t req,
  input  logic                    ctrl_dp_ex1_inst_pipe_down,
  input  logic                    ifu_vpu_warm_up,
  output fmau_pkg::fmau_prod_t    ex2_mult_data,
  output logic                    ex2_mult_vld
);

  // Aligned EX1 fractions
  fmau_pkg::fmau_frac_pair_t ex1_fracs;

  fmau_frac_unpack i_frac_unpack (
    .req   (req),
    .fracs (ex1_fracs)
  );

  fmau_frac_mult #(
    .lo_split (lo_split)
  ) i_frac_mult (
    .fmau_ex2_data_clk          (fmau_ex2_data_clk),
    .rst_n                      (rst_n),
    .ctrl_dp_ex1_inst_pipe_down (ctrl_dp_ex1_inst_pipe_down),
    .ifu_vpu_warm_up            (ifu_vpu_warm_up),
    .fracs                      (ex1_fracs),
    .ex2_mult_data              (ex2_mult_data),
    .ex2_mult_vld               (ex2_mult_vld)
  );

  // Fraction select is an AND-OR mux, two formats at once would merge fields
  a_fmt_onehot : assert property (
    @(posedge fmau_ex2_data_clk) disable iff (!rst_n)
    ctrl_dp_ex1_inst_pipe_down |-> $onehot(req.fmt)
  ) else $error("format not one-hot on pipe-down");

endmodule

// File: frac_mult/fmau_frac_mult.sv
module fmau_frac_mult #(
  parameter int unsigned lo_split = 27
) (
  input  logic                      fmau_ex2_data_clk,
  input  logic                      rst_n,
  input  logic                      ctrl_dp_ex1_inst_pipe_down,
  input  logic                      ifu_vpu_warm_up,
  input  fmau_pkg::fmau_frac_pair_t fracs,
  output fmau_pkg::fmau_prod_t      ex2_mult_data,
  output logic                      ex2_mult_vld
);

  localparam int unsigned frac_w = fmau_pkg::frac_width;
  localparam int unsigned pp_w = fmau_pkg::pp_width;
  localparam int unsigned prod_w = fmau_pkg::prod_width;

  logic [lo_split-1:0] mult_b_lo;
  logic [lo_split-1:0] mult_b_hi;
  fmau_pkg::fmau_pp_t  ex1_pp_lo;
  fmau_pkg::fmau_pp_t  ex1_pp_hi;
  fmau_pkg::fmau_pp_t  ex2_pp_lo;
  fmau_pkg::fmau_pp_t  ex2_pp_hi;
  logic [prod_w-1:0]   ex2_vec_0;
  logic [prod_w-1:0]   ex2_vec_1;
  logic [prod_w-1:0]   ex2_vec_2;
  logic [prod_w-1:0]   ex2_vec_3;
  logic [prod_w-1:0]   ex2_row1_sum;
  logic [prod_w-1:0]   ex2_row1_carry;
  logic [prod_w-1:0]   ex2_row2_sum;
  logic [prod_w-1:0]   ex2_row2_carry;

  // ========================================
  // EX1 operand split and partial products
  // ========================================

  assign mult_b_lo = fracs.frac_1[lo_split-1:0];

  // Upper slice is narrower, zero-extend to reuse the same multiplier
  assign mult_b_hi = lo_split'(fracs.frac_1[frac_w-1:lo_split]);

  fmau_partial_mult #(
    .a_width (frac_w),
    .b_width (lo_split)
  ) i_mult_lo (
    .a  (fracs.frac_0),
    .b  (mult_b_lo),
    .pp (ex1_pp_lo)
  );

  fmau_partial_mult #(
    .a_width (frac_w),
    .b_width (lo_split)
  ) i_mult_hi (
    .a  (fracs.frac_0),
    .b  (mult_b_hi),
    .pp (ex1_pp_hi)
  );

  // ========================================
  // EX2 pipe registers
  // ========================================

  // Warm-up toggles the wide flops ahead of real traffic
  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (ctrl_dp_ex1_inst_pipe_down || ifu_vpu_warm_up)
    begin
      ex2_pp_lo <= ex1_pp_lo;
      ex2_pp_hi <= ex1_pp_hi;
    end
  end

  // Only a real pipe-down marks the product as fresh
  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (!rst_n)
    begin
      ex2_mult_vld <= 1'b0;
    end
    else
    begin
      ex2_mult_vld <= ctrl_dp_ex1_inst_pipe_down;
    end
  end

  // ========================================
  // EX2 alignment and 4:2 reduction
  // ========================================

  // Low pair, sign-extended to full width
  assign ex2_vec_0 = {{(prod_w - pp_w){ex2_pp_lo.out0[pp_w-1]}}, ex2_pp_lo.out0};
  assign ex2_vec_1 = {{(prod_w - pp_w){ex2_pp_lo.out1[pp_w-1]}}, ex2_pp_lo.out1};

  // High pair weighs 2**lo_split, top bits fall off modulo 2**prod_w
  assign ex2_vec_2 = {ex2_pp_hi.out0[prod_w-lo_split-1:0], {lo_split{1'b0}}};
  assign ex2_vec_3 = {ex2_pp_hi.out1[prod_w-lo_split-1:0], {lo_split{1'b0}}};

  // First full-adder row
  assign ex2_row1_sum   = ex2_vec_0 ^ ex2_vec_1 ^ ex2_vec_2;
  assign ex2_row1_carry = ((ex2_vec_0 & ex2_vec_1) |
                           (ex2_vec_0 & ex2_vec_2) |
                           (ex2_vec_1 & ex2_vec_2)) << 1;

  // Second row folds in the last vector
  assign ex2_row2_sum   = ex2_row1_sum ^ ex2_row1_carry ^ ex2_vec_3;
  assign ex2_row2_carry = ((ex2_row1_sum & ex2_row1_carry) |
                           (ex2_row1_sum & ex2_vec_3) |
                           (ex2_row1_carry & ex2_vec_3)) << 1;

  // Single carry-propagate add
  assign ex2_mult_data = ex2_row2_sum + ex2_row2_carry;

  // Fractions moving into EX2 must be resolved
  a_pipe_down_known : assert property (
    @(posedge fmau_ex2_data_clk) disable iff (!rst_n)
    ctrl_dp_ex1_inst_pipe_down |-> !$isunknown(fracs)
  ) else $error("unknown fractions on pipe-down");

  // A reset cycle never leaves a valid product behind
  a_vld_reset : assert property (
    @(posedge fmau_ex2_data_clk)
    !rst_n |=> !ex2_mult_vld
  ) else $error("ex2_mult_vld set after reset");

endmodule

// File: frac_mult/fmau_partial_mult.sv
module fmau_partial_mult #(
  parameter int unsigned a_width = 53,
  parameter int unsigned b_width = 27
) (
  input  logic [a_width-1:0] a,
  input  logic [b_width-1:0] b,
  output fmau_pkg::fmau_pp_t pp
);

  localparam int unsigned w = fmau_pkg::pp_width;

  // b is unsigned, so one extra zero above its msb makes it a valid
  // signed Booth operand
  localparam int unsigned n_digit = (b_width + 2) / 2;

  logic [2*n_digit:0] b_ext;
  logic [w-1:0]       row       [n_digit];
  logic [w-1:0]       neg_bits;
  logic [w-1:0]       sum_row   [n_digit];
  logic [w-1:0]       carry_row [n_digit];
  logic [w-1:0]       last_sum;
  logic [w-1:0]       last_carry;

  // Implicit zero below bit 0, zero fill above the msb
  assign b_ext = {{(2 * n_digit - b_width){1'b0}}, b, 1'b0};

  // ========================================
  // Radix-4 Booth recoding
  // ========================================

  for (genvar i = 0; i < n_digit; i++)
  begin : g_digit
    logic [2:0]   grp;
    logic         neg;
    logic         one;
    logic         two;
    logic [w-1:0] mag;

    assign grp = b_ext[2*i+2:2*i];
    assign neg = grp[2];
    assign one = grp[1] ^ grp[0];
    assign two = (grp[2] & ~grp[1] & ~grp[0]) | (~grp[2] & grp[1] & grp[0]);

    // Select 0, a or 2a
    assign mag = ({w{one}} & w'(a)) | ({w{two}} & (w'(a) << 1));

    // Ones complement here, the +1 rides in neg_bits
    assign row[i] = (mag ^ {w{neg}}) << (2 * i);
  end

  // Two's complement correction, one bit per negative digit
  always_comb
  begin
    neg_bits = '0;
    for (int i = 0; i < n_digit; i++)
    begin
      neg_bits[2*i] = b_ext[2*i+2];
    end
  end

  // ========================================
  // Carry-save reduction
  // ========================================

  // Correction vector seeds the carry side of the first row
  assign sum_row[0]   = row[0];
  assign carry_row[0] = neg_bits;

  for (genvar i = 1; i < n_digit; i++)
  begin : g_csa
    assign sum_row[i] = sum_row[i-1] ^ carry_row[i-1] ^ row[i];
    assign carry_row[i] = ((sum_row[i-1] & carry_row[i-1]) |
                           (sum_row[i-1] & row[i]) |
                           (carry_row[i-1] & row[i])) << 1;
  end

  // Move the carry msb into the sum msb. Adding 2**(w-1) to both
  // leaves the modular sum alone, and a carry vector with a clear msb
  // lets the low pair be sign-extended downstream without error
  assign last_sum   = {sum_row[n_digit-1][w-1] ^ carry_row[n_digit-1][w-1],
                       sum_row[n_digit-1][w-2:0]};
  assign last_carry = {1'b0, carry_row[n_digit-1][w-2:0]};

  assign pp = '{out0: last_sum, out1: last_carry};

  // Redundant pair must always reduce to the true product
  always_comb
  begin
    if (!$isunknown({a, b}))
    begin
      assert final (w'(pp.out0 + pp.out1) == w'(a) * w'(b))
        else $error("partial multiplier pair does not sum to a*b");
    end
  end

endmodule

// File: hdl/fmau_frac_unpack.sv
module fmau_frac_unpack (
  input  fmau_pkg::fmau_ex1_req_t   req,
  output fmau_pkg::fmau_frac_pair_t fracs
);

  localparam int unsigned df = fmau_pkg::double_frac;
  localparam int unsigned sf = fmau_pkg::single_frac;
  localparam int unsigned hf = fmau_pkg::f16_frac;
  localparam int unsigned bf = fmau_pkg::bf16_frac;

  // ========================================
  // Fraction selection
  // ========================================

  // Narrow fractions are pushed up to the double msb so every format
  // lands on the same binary point in the 53-bit multiplier
  function automatic fmau_pkg::fmau_frac_t align_frac(
    input fmau_pkg::fmau_fmt_t                 fmt,
    input logic [fmau_pkg::fpu_width-1:0]      src,
    input logic                                denorm
  );
    logic [df-1:0] field;
    logic          hidden;

    field = ({df{fmt.double}} & src[df-1:0])
          | ({df{fmt.single}} & {src[sf-1:0], {(df - sf){1'b0}}})
          | ({df{fmt.f16}}    & {src[hf-1:0], {(df - hf){1'b0}}})
          | ({df{fmt.bf16}}   & {src[bf-1:0], {(df - bf){1'b0}}});

    // Denormal operands carry no implicit one
    hidden = ~denorm;

    return {hidden, field};
  endfunction

  // Same selection for both sources, each with its own denormal bit
  assign fracs = '{
    frac_0: align_frac(req.fmt, req.srcv0, req.id_reg[0]),
    frac_1: align_frac(req.fmt, req.srcv1, req.id_reg[1])
  };

endmodule

// File: common/fmau_pkg.sv
package fmau_pkg;

  // ========================================
  // Operand and fraction widths
  // ========================================

  // Full vector operand
  localparam int unsigned fpu_width = 64;

  // Stored fraction widths per format
  localparam int unsigned double_frac = 52;
  localparam int unsigned single_frac = 23;
  localparam int unsigned f16_frac = 10;
  localparam int unsigned bf16_frac = 7;

  // Left-aligned fraction plus hidden bit
  localparam int unsigned frac_width = double_frac + 1;

  // Full 53x53 product
  localparam int unsigned prod_width = 2 * frac_width;

  // Operand 1 is split into a low slice of this width and the rest
  localparam int unsigned lo_split = 27;

  // Carry-save width of one 53x27 partial multiplier
  // Product needs 80 bits, the rest is Booth headroom
  localparam int unsigned pp_width = 84;

  // ========================================
  // Types
  // ========================================

  // One-hot operation format, exactly one bit set per instruction
  typedef struct packed {
    logic double;
    logic single;
    logic f16;
    logic bf16;
  } fmau_fmt_t;

  // EX1 request as it leaves the decode/issue stage
  typedef struct packed {
    fmau_fmt_t             fmt;
    logic [1:0]            id_reg;
    logic [fpu_width-1:0]  srcv0;
    logic [fpu_width-1:0]  srcv1;
  } fmau_ex1_req_t;

  // Aligned fraction with hidden bit at the msb
  typedef logic [frac_width-1:0] fmau_frac_t;

  // Fraction product as seen by the adder stage
  typedef logic [prod_width-1:0] fmau_prod_t;

  // Both aligned fractions of one request
  typedef struct packed {
    fmau_frac_t frac_0;
    fmau_frac_t frac_1;
  } fmau_frac_pair_t;

  // Redundant product of one partial multiplier
  // out0 + out1 equals a*b modulo 2**pp_width
  typedef struct packed {
    logic [pp_width-1:0] out0;
    logic [pp_width-1:0] out1;
  } fmau_pp_t;

endpackage
